// ==== src/cache_pkg.sv ====
// cache_pkg: geometry constants and shared bus structs for the cache storage block
package cache_pkg;

  ////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////
  localparam int XLEN          = 32;
  localparam int WAYS          = 2;
  localparam int SETS          = 8;
  localparam int IDX_BITS      = 3;
  localparam int BLK_BITS      = 128;
  localparam int BLK_BYTES     = 16;
  localparam int BLK_OFFS_BITS = 4;
  localparam int DAT_OFFS_BITS = 2;                                // word select within a line
  localparam int TAG_BITS      = XLEN - IDX_BITS - BLK_OFFS_BITS;

  ////////////////////////////////////////////////////////////
  // basic types
  ////////////////////////////////////////////////////////////
  typedef logic [WAYS-1:0]     way_vec_t;   // one-hot or way set
  typedef logic [BLK_BITS-1:0] line_t;

  // read lookup from the core side
  typedef struct packed {
    logic                rreq;
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
  } lookup_req_t;

  // line fill from the bus interface
  typedef struct packed {
    logic                filling;
    logic                ack;
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    way_vec_t            way;     // one-hot target way
    line_t               line;
    logic                dirty;
  } fill_req_t;

  // write buffer store, one word
  typedef struct packed {
    logic                     we;
    logic [IDX_BITS-1:0]      idx;
    logic [XLEN/8-1:0]        be;
    logic [DAT_OFFS_BITS-1:0] offs;
    logic [XLEN-1:0]          data;
    way_vec_t                 ways_hit;
  } wb_req_t;

  // lookup context, travels alongside the array read
  typedef struct packed {
    logic                valid;   // read owned the array slot
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    way_vec_t            victim;
  } rd_ctx_t;

  // memory command, control -> tag and data stores
  typedef struct packed {
    logic [IDX_BITS-1:0]  idx;
    way_vec_t             tag_we;
    way_vec_t             dat_we;
    way_vec_t             dirty_we;
    logic                 dirty_val;
    logic [TAG_BITS-1:0]  fill_tag;
    line_t                wdata;
    logic [BLK_BYTES-1:0] wbe;
    rd_ctx_t              rd_ctx;
  } mem_ctrl_t;

  typedef struct packed {
    logic                valid;
    logic                dirty;
    logic [TAG_BITS-1:0] tag;
  } tag_entry_t;

  typedef tag_entry_t [WAYS-1:0] way_tags_t;

  // eviction candidate
  typedef struct packed {
    logic [IDX_BITS-1:0] idx;
    logic [TAG_BITS-1:0] tag;
    line_t               line;
    logic                dirty;
  } evict_t;

endpackage

// ==== src/cache_ctrl.sv ====
// cache_ctrl: arbitrates the array index, builds write data and enables, delays lookup context
`timescale 1ns/10ps

module cache_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  cache_pkg::lookup_req_t rd_i,
  input  cache_pkg::fill_req_t   fill_i,
  input  cache_pkg::wb_req_t     wb_i,
  input  cache_pkg::way_vec_t    victim_i,
  output cache_pkg::mem_ctrl_t   ctrl_o
);
  import cache_pkg::*;

  logic                 bus_we;   // fill beat accepted this cycle
  logic                 wb_we;    // store gets the slot, no read pending
  way_vec_t             fill_we;  // per-way fill strobe
  way_vec_t             store_we; // per-way store strobe
  line_t                wb_line;  // store word in its lane
  logic [BLK_BYTES-1:0] wb_be;    // store byte enables in its lane
  rd_ctx_t              ctx_d;
  rd_ctx_t              ctx_q;

  ////////////////////////////////////////////////////////////
  // write strobes
  ////////////////////////////////////////////////////////////
  assign bus_we = fill_i.filling & fill_i.ack;
  assign wb_we  = wb_i.we & ~rd_i.rreq;

  assign fill_we  = {WAYS{bus_we}} & fill_i.way;
  assign store_we = {WAYS{wb_we & ~bus_we}} & wb_i.ways_hit; // bus owns idx on overlap

  // place the store word at its offset in the line
  assign wb_line = line_t'(wb_i.data) << (wb_i.offs * XLEN);
  assign wb_be   = BLK_BYTES'(wb_i.be) << (wb_i.offs * (XLEN / 8));

  ////////////////////////////////////////////////////////////
  // lookup context
  ////////////////////////////////////////////////////////////
  // a write stealing the index kills the read
  always_comb
  begin
    ctx_d.valid  = rd_i.rreq & ~bus_we & ~wb_we;
    ctx_d.idx    = rd_i.idx;
    ctx_d.tag    = rd_i.tag;
    ctx_d.victim = victim_i;
  end

  // aligned with the registered array read
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ctx_q <= '0;
    end
    else
    begin
      ctx_q <= ctx_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // memory command
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    // index priority: fill, store, read
    if (bus_we)     ctrl_o.idx = fill_i.idx;
    else if (wb_we) ctrl_o.idx = wb_i.idx;
    else            ctrl_o.idx = rd_i.idx;

    ctrl_o.tag_we    = fill_we;
    ctrl_o.dat_we    = fill_we | store_we;
    ctrl_o.dirty_we  = fill_we | store_we;       // store always dirties
    ctrl_o.dirty_val = bus_we ? fill_i.dirty : 1'b1;
    ctrl_o.fill_tag  = fill_i.tag;
    ctrl_o.wdata     = bus_we ? fill_i.line : wb_line;
    ctrl_o.wbe       = bus_we ? {BLK_BYTES{1'b1}} : wb_be; // full line on fill
    ctrl_o.rd_ctx    = ctx_q;
  end

endmodule

// ==== src/tag_store.sv ====
// tag_store: per-way tag arrays with valid and dirty flops, read out one cycle after the request
`timescale 1ns/10ps

module tag_store (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  cache_pkg::mem_ctrl_t ctrl_i,
  output cache_pkg::way_tags_t tags_o,
  output cache_pkg::rd_ctx_t   ctx_o
);
  import cache_pkg::*;

  logic [IDX_BITS-1:0] rd_idx; // index of the lookup now at the array output

  assign rd_idx = ctrl_i.rd_ctx.idx;

  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    logic [TAG_BITS-1:0] tag_mem [SETS]; // tag ram
    logic [TAG_BITS-1:0] tag_rd_q;       // registered tag read
    logic [SETS-1:0]     valid_q;        // per-set valid
    logic [SETS-1:0]     dirty_q;        // per-set dirty

    ////////////////////////////////////////////////////////////
    // tag array, read-first
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i)
    begin
      if (ctrl_i.tag_we[w])
      begin
        tag_mem[ctrl_i.idx] <= ctrl_i.fill_tag;
      end
      tag_rd_q <= tag_mem[ctrl_i.idx];
    end

    // valid set by fill only, dirty by fill or store
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        valid_q <= '0;
        dirty_q <= '0;
      end
      else
      begin
        if (ctrl_i.tag_we[w])
        begin
          valid_q[ctrl_i.idx] <= 1'b1;
        end
        if (ctrl_i.dirty_we[w])
        begin
          dirty_q[ctrl_i.idx] <= ctrl_i.dirty_val;
        end
      end
    end

    // flags picked at the delayed index
    assign tags_o[w].tag   = tag_rd_q;
    assign tags_o[w].valid = valid_q[rd_idx];
    assign tags_o[w].dirty = dirty_q[rd_idx];
  end

  // context stays paired with the tag read
  assign ctx_o = ctrl_i.rd_ctx;

endmodule

// ==== src/data_store.sv ====
// data_store: per-way line arrays with byte-enabled writes and registered read
`timescale 1ns/10ps

module data_store (
  input  logic                                   clk_i,
  input  cache_pkg::mem_ctrl_t                   ctrl_i,
  output cache_pkg::line_t [cache_pkg::WAYS-1:0] lines_o
);
  import cache_pkg::*;

  ////////////////////////////////////////////////////////////
  // one line ram per way
  ////////////////////////////////////////////////////////////
  for (genvar w = 0; w < WAYS; w++)
  begin : g_way
    line_t mem [SETS]; // line storage
    line_t rd_q;       // registered read

    // byte lanes: full line on fill, one word on store
    always_ff @(posedge clk_i)
    begin
      for (int b = 0; b < BLK_BYTES; b++)
      begin
        if (ctrl_i.dat_we[w] && ctrl_i.wbe[b])
        begin
          mem[ctrl_i.idx][b*8 +: 8] <= ctrl_i.wdata[b*8 +: 8];
        end
      end
    end

    // old contents on a write cycle
    always_ff @(posedge clk_i)
    begin
      rd_q <= mem[ctrl_i.idx];
    end

    assign lines_o[w] = rd_q;
  end

endmodule

// ==== src/lookup_result.sv ====
// lookup_result: hit detection, hit line and victim select, output registers held on stall
`timescale 1ns/10ps

module lookup_result (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   stall_i,
  input  cache_pkg::rd_ctx_t                     ctx_i,
  input  cache_pkg::way_tags_t                   tags_i,
  input  cache_pkg::line_t [cache_pkg::WAYS-1:0] lines_i,
  output logic                                   hit_o,
  output cache_pkg::way_vec_t                    ways_hit_o,
  output cache_pkg::line_t                       cache_line_o,
  output cache_pkg::evict_t                      evict_o,
  output cache_pkg::way_vec_t                    fill_way_o
);
  import cache_pkg::*;

  way_vec_t            way_hit;   // masked tag compare
  line_t               hit_line;  // and-or of hit ways
  line_t               vic_line;
  logic [TAG_BITS-1:0] vic_tag;
  logic                vic_dirty; // victim valid and dirty
  logic                evict_dirty_q;
  logic [IDX_BITS-1:0] evict_idx_q;
  logic [TAG_BITS-1:0] evict_tag_q;
  line_t               evict_line_q;

  ////////////////////////////////////////////////////////////
  // compare and select
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    hit_line  = '0;
    vic_line  = '0;
    vic_tag   = '0;
    vic_dirty = 1'b0;
    for (int w = 0; w < WAYS; w++)
    begin
      way_hit[w] = ctx_i.valid & tags_i[w].valid & (tags_i[w].tag == ctx_i.tag);
      hit_line  |= lines_i[w] & {BLK_BITS{way_hit[w]}};
      vic_line  |= lines_i[w] & {BLK_BITS{ctx_i.victim[w]}};  // victim is one-hot
      vic_tag   |= tags_i[w].tag & {TAG_BITS{ctx_i.victim[w]}};
      vic_dirty |= ctx_i.victim[w] & tags_i[w].valid & tags_i[w].dirty;
    end
  end

  ////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      hit_o         <= 1'b0;
      ways_hit_o    <= '0;
      fill_way_o    <= '0;
      evict_dirty_q <= 1'b0;
    end
    else if (!stall_i)
    begin
      hit_o         <= |way_hit;
      ways_hit_o    <= way_hit;
      fill_way_o    <= ctx_i.victim;
      evict_dirty_q <= vic_dirty;
    end
  end

  // line and address payload
  always_ff @(posedge clk_i)
  begin
    if (!stall_i)
    begin
      cache_line_o <= hit_line;
      evict_idx_q  <= ctx_i.idx;
      evict_tag_q  <= vic_tag;
      evict_line_q <= vic_line;
    end
  end

  assign evict_o.idx   = evict_idx_q;
  assign evict_o.tag   = evict_tag_q;
  assign evict_o.line  = evict_line_q;
  assign evict_o.dirty = evict_dirty_q;

endmodule

// ==== src/cache_memory.sv ====
// cache_memory: storage block top, control plus tag and data stores plus result stage
`timescale 1ns/10ps

module cache_memory (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   stall_i,
  input  cache_pkg::lookup_req_t rd_i,
  input  cache_pkg::fill_req_t   fill_i,
  input  cache_pkg::wb_req_t     wb_i,
  input  cache_pkg::way_vec_t    victim_i,
  output logic                   hit_o,
  output cache_pkg::way_vec_t    ways_hit_o,
  output cache_pkg::line_t       cache_line_o,
  output cache_pkg::evict_t      evict_o,
  output cache_pkg::way_vec_t    fill_way_o
);
  import cache_pkg::*;

  mem_ctrl_t           mem_ctrl; // per-cycle array command
  way_tags_t           way_tags; // tag read, one cycle late
  rd_ctx_t             rd_ctx;   // lookup context, same cycle as way_tags
  line_t  [WAYS-1:0]   way_lines;

  ////////////////////////////////////////////////////////////
  // control and arrays
  ////////////////////////////////////////////////////////////
  cache_ctrl u_ctrl (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .rd_i     ( rd_i     ),
    .fill_i   ( fill_i   ),
    .wb_i     ( wb_i     ),
    .victim_i ( victim_i ),
    .ctrl_o   ( mem_ctrl )
  );

  tag_store u_tags (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .ctrl_i ( mem_ctrl ),
    .tags_o ( way_tags ),
    .ctx_o  ( rd_ctx   )
  );

  data_store u_data (
    .clk_i   ( clk_i     ),
    .ctrl_i  ( mem_ctrl  ),
    .lines_o ( way_lines )
  );

  // second pipeline stage
  lookup_result u_result (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .stall_i      ( stall_i      ),
    .ctx_i        ( rd_ctx       ),
    .tags_i       ( way_tags     ),
    .lines_i      ( way_lines    ),
    .hit_o        ( hit_o        ),
    .ways_hit_o   ( ways_hit_o   ),
    .cache_line_o ( cache_line_o ),
    .evict_o      ( evict_o      ),
    .fill_way_o   ( fill_way_o   )
  );

endmodule

// ==== tests/cache_memory_properties.sv ====
// cache_memory_properties: output protocol checks for the cache storage top
`timescale 1ns/10ps

module cache_memory_properties (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   stall_i,
  input cache_pkg::lookup_req_t rd_i,
  input logic                   hit_o,
  input cache_pkg::way_vec_t    ways_hit_o,
  input cache_pkg::line_t       cache_line_o,
  input cache_pkg::evict_t      evict_o,
  input cache_pkg::way_vec_t    fill_way_o
);
  import cache_pkg::*;

  int         fails = 0;  // assertion failures so far
  logic [1:0] rd_seen_q;  // [0] read sampled, [1] its result stage reached

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_seen_q <= '0;
    end
    else
    begin
      rd_seen_q <= {rd_seen_q[0], rd_seen_q[0] | rd_i.rreq};
    end
  end

  ////////////////////////////////////////////////////////////
  // output rules
  ////////////////////////////////////////////////////////////
  a_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(ways_hit_o))
  else
  begin
    $error("ways_hit_o has more than one way set");
    fails++;
  end

  a_hit_or: assert property (@(posedge clk_i) disable iff (!rst_ni) hit_o == |ways_hit_o)
  else
  begin
    $error("hit_o does not match the OR of ways_hit_o");
    fails++;
  end

  // registers frozen for the cycle after a sampled stall
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i |=> $stable(hit_o) && $stable(ways_hit_o) && $stable(cache_line_o) &&
                $stable(evict_o) && $stable(fill_way_o))
  else
  begin
    $error("lookup outputs changed while stall was high");
    fails++;
  end

  a_no_early_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rd_seen_q[1] |-> !hit_o)
  else
  begin
    $error("hit reported before any read completed");
    fails++;
  end

endmodule

// ==== tests/tb_cache_memory.sv ====
// tb_cache_memory drives the cache storage block and checks it against a shadow model
`timescale 1ns/10ps

module tb_cache_memory;
  import cache_pkg::*;

  localparam int RST_CYCLES  = 4;
  localparam int TEST_CYCLES = RST_CYCLES + 1 + SETS + 2*WAYS*SETS + SETS + 2*SETS + 14;

  typedef struct packed {
    logic     stall;     // stall launched with this request
    logic     chk_evict; // slot not taken by a write so evict idx and dirty are known
    logic     chk_vline; // victim way valid so its tag and line are known
    logic     hit;
    way_vec_t ways;
    line_t    line;
    way_vec_t fill_way;
    evict_t   evict;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        stall;
  lookup_req_t rd;
  fill_req_t   fill;
  wb_req_t     wb;
  way_vec_t    victim;
  logic        hit;
  way_vec_t    ways_hit;
  line_t       cache_line;
  evict_t      evict;
  way_vec_t    fill_way;

  integer              seed = 32'h89cb4561;
  int                  errors = 0;
  expect_t             exp_q [$];          // up to two reads in flight
  expect_t             held;               // what the output registers should show
  line_t               sh_line  [WAYS][SETS];
  logic [TAG_BITS-1:0] sh_tag   [WAYS][SETS];
  logic                sh_valid [WAYS][SETS];
  logic                sh_dirty [WAYS][SETS];
  logic [TAG_BITS-1:0] base_tag [SETS];   // bit 0 picks the way

  cache_memory UUT (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .stall_i      ( stall      ),
    .rd_i         ( rd         ),
    .fill_i       ( fill       ),
    .wb_i         ( wb         ),
    .victim_i     ( victim     ),
    .hit_o        ( hit        ),
    .ways_hit_o   ( ways_hit   ),
    .cache_line_o ( cache_line ),
    .evict_o      ( evict      ),
    .fill_way_o   ( fill_way   )
  );

  bind cache_memory cache_memory_properties u_props (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .stall_i      ( stall_i      ),
    .rd_i         ( rd_i         ),
    .hit_o        ( hit_o        ),
    .ways_hit_o   ( ways_hit_o   ),
    .cache_line_o ( cache_line_o ),
    .evict_o      ( evict_o      ),
    .fill_way_o   ( fill_way_o   )
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    #(TEST_CYCLES * 8 + 200);
    $display("timeout: the test sequence did not finish in time");
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // request builders
  ////////////////////////////////////////////////////////////
  function automatic logic [TAG_BITS-1:0] way_tag(input int s, input int w);
    return (base_tag[s] & ~TAG_BITS'(1)) | TAG_BITS'(w);
  endfunction

  function automatic line_t rand_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic lookup_req_t read_req(input int idx, input logic [TAG_BITS-1:0] tag);
    lookup_req_t r;
    r.rreq = 1'b1;
    r.idx  = IDX_BITS'(idx);
    r.tag  = tag;
    return r;
  endfunction

  function automatic fill_req_t fill_req(input int idx, input int w, input logic dirty);
    fill_req_t f;
    f.filling = 1'b1;
    f.ack     = 1'b1;
    f.idx     = IDX_BITS'(idx);
    f.tag     = way_tag(idx, w);
    f.way     = way_vec_t'(1 << w);
    f.line    = rand_line();
    f.dirty   = dirty;
    return f;
  endfunction

  function automatic wb_req_t store_req(input int idx, input int w);
    wb_req_t     s;
    logic [31:0] rnd;
    rnd        = $random(seed);
    s.we       = 1'b1;
    s.idx      = IDX_BITS'(idx);
    s.be       = rnd[XLEN/8-1:0];   // random byte lanes
    s.offs     = DAT_OFFS_BITS'($random(seed));
    s.data     = $random(seed);
    s.ways_hit = way_vec_t'(1 << w);
    return s;
  endfunction

  task automatic report_mismatch(input string name, input line_t exp_v, input line_t got_v);
    $display("Error: %s expected %0h, got %0h at %0t ns", name, exp_v, got_v, $time);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////
  // checking and the per-cycle driver
  ////////////////////////////////////////////////////////////
  task automatic check_front();
    expect_t e;
    e = exp_q.pop_front();
    if (!exp_q[0].stall) // stall of the next request gates the output register
    begin
      held = e;
    end
    assert (hit == held.hit) else report_mismatch("hit_o", held.hit, hit);
    assert (ways_hit == held.ways) else report_mismatch("ways_hit_o", held.ways, ways_hit);
    assert (cache_line == held.line) else report_mismatch("cache_line_o", held.line, cache_line);
    assert (fill_way == held.fill_way) else report_mismatch("fill_way_o", held.fill_way, fill_way);
    if (held.chk_evict)
    begin
      assert (evict.idx == held.evict.idx)
        else report_mismatch("evict_o.idx", held.evict.idx, evict.idx);
      assert (evict.dirty == held.evict.dirty)
        else report_mismatch("evict_o.dirty", held.evict.dirty, evict.dirty);
    end
    if (held.chk_vline)
    begin
      assert (evict.tag == held.evict.tag)
        else report_mismatch("evict_o.tag", held.evict.tag, evict.tag);
      assert (evict.line == held.evict.line)
        else report_mismatch("evict_o.line", held.evict.line, evict.line);
    end
  endtask

  task automatic run_cycle(input lookup_req_t r, input fill_req_t f, input wb_req_t s,
                           input int vw, input logic st);
    expect_t e;
    logic    bus_we;
    logic    wb_we;
    @(negedge clk);
    if (exp_q.size() == 2)
    begin
      check_front();
    end
    rd     = r;
    fill   = f;
    wb     = s;
    victim = way_vec_t'(1 << vw);
    stall  = st;
    bus_we = f.filling & f.ack;
    wb_we  = s.we & ~r.rreq;
    e           = '0;
    e.stall     = st;
    e.fill_way  = victim;
    e.chk_evict = !bus_we && !wb_we;  // a write steals the index
    for (int w = 0; w < WAYS; w++)
    begin
      if (r.rreq && e.chk_evict && sh_valid[w][r.idx] && sh_tag[w][r.idx] == r.tag)
      begin
        e.ways[w] = 1'b1;
        e.line   |= sh_line[w][r.idx];
      end
    end
    e.hit         = |e.ways;
    e.evict.idx   = r.idx;
    e.evict.dirty = sh_valid[vw][r.idx] & sh_dirty[vw][r.idx];
    e.evict.tag   = sh_tag[vw][r.idx];
    e.evict.line  = sh_line[vw][r.idx];
    e.chk_vline   = e.chk_evict & sh_valid[vw][r.idx];
    exp_q.push_back(e);
    // writes land after this read sampled the model
    for (int w = 0; w < WAYS; w++)
    begin
      if (bus_we && f.way[w])
      begin
        sh_line[w][f.idx]  = f.line;
        sh_tag[w][f.idx]   = f.tag;
        sh_valid[w][f.idx] = 1'b1;
        sh_dirty[w][f.idx] = f.dirty;
      end
      else if (wb_we && !bus_we && s.ways_hit[w])
      begin
        for (int b = 0; b < XLEN/8; b++)
        begin
          if (s.be[b])
          begin
            sh_line[w][s.idx][(s.offs*(XLEN/8) + b)*8 +: 8] = s.data[b*8 +: 8];
          end
        end
        sh_dirty[w][s.idx] = 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    int vw;
    rst_n  = 1'b0;
    stall  = 1'b0;
    rd     = '0;
    fill   = '0;
    wb     = '0;
    victim = way_vec_t'(1);
    held   = '0;
    for (int s = 0; s < SETS; s++)
    begin
      base_tag[s] = TAG_BITS'($random(seed));
      for (int w = 0; w < WAYS; w++)
      begin
        sh_valid[w][s] = 1'b0;
        sh_dirty[w][s] = 1'b0;
      end
    end
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // nothing hits or is dirty right after reset
    for (int s = 0; s < SETS; s++)
    begin
      run_cycle(read_req(s, TAG_BITS'($random(seed))), '0, '0, s % WAYS, 1'b0);
    end
    // way 1 filled dirty and way 0 clean
    for (int s = 0; s < SETS; s++)
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        run_cycle('0, fill_req(s, w, w[0]), '0, 0, 1'b0);
      end
    end
    for (int s = 0; s < SETS; s++) // back to back hits
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        run_cycle(read_req(s, way_tag(s, w)), '0, '0, w, 1'b0);
      end
    end
    for (int s = 0; s < SETS; s++) // tag bit 1 flipped so these miss
    begin
      run_cycle(read_req(s, way_tag(s, 0) ^ TAG_BITS'(2)), '0, '0, 1, 1'b0);
    end
    // partial stores read back with the stored way as victim
    for (int s = 0; s < SETS; s++)
    begin
      vw = $random(seed) & 1;
      run_cycle('0, '0, store_req(s, vw), 0, 1'b0);
      run_cycle(read_req(s, way_tag(s, vw)), '0, '0, vw, 1'b0);
    end
    // read colliding with a fill gets no hit
    run_cycle(read_req(3, way_tag(3, 0)), fill_req(3, 0, 1'b1), '0, 0, 1'b0);
    run_cycle(read_req(3, way_tag(3, 0)), '0, '0, 0, 1'b0);
    run_cycle('0, fill_req(5, 1, 1'b0), '0, 0, 1'b0);
    run_cycle(read_req(5, way_tag(5, 1)), '0, '0, 1, 1'b0);
    // reads completing inside the stall window are dropped
    run_cycle(read_req(1, way_tag(1, 1)), '0, '0, 1, 1'b0);
    run_cycle(read_req(2, way_tag(2, 0)), '0, '0, 0, 1'b1);
    run_cycle(read_req(4, way_tag(4, 1)), '0, '0, 1, 1'b1);
    run_cycle(read_req(6, way_tag(6, 0)), '0, '0, 0, 1'b1);
    run_cycle(read_req(7, way_tag(7, 1)), '0, '0, 1, 1'b0);
    run_cycle(read_req(0, way_tag(0, 0)), '0, '0, 0, 1'b0);
    repeat (4)
    begin
      run_cycle('0, '0, '0, 0, 1'b0); // drain
    end

    $display("value check errors: %0d, assertion failures: %0d", errors, UUT.u_props.fails);
    if (errors == 0 && UUT.u_props.fails == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== build.f ====
src/cache_pkg.sv
src/cache_ctrl.sv
src/tag_store.sv
src/data_store.sv
src/lookup_result.sv
src/cache_memory.sv
tests/cache_memory_properties.sv
tests/tb_cache_memory.sv
